//--- source/parser_pkg.sv
package parser_pkg;

    // Flit and sideband widths.
    localparam int FLIT_W   = 512;
    localparam int EMPTY_W  = 6;
    localparam int PKT_ID_W = 10;
    localparam int FLITS_W  = 8;

    // Header field widths.
    localparam int ETH_TYPE_W  = 16;
    localparam int IP_VER_W    = 4;
    localparam int IP_IHL_W    = 4;
    localparam int LEN_W       = 16;
    localparam int IP_PROT_W   = 8;
    localparam int IP_ADDR_W   = 32;
    localparam int PORT_W      = 16;
    localparam int TCP_DO_W    = 4;
    localparam int TCP_FLAGS_W = 9;

    // Protocol constants.
    localparam logic [ETH_TYPE_W-1:0] PROT_ETH      = 16'h0800;
    localparam logic [IP_VER_W-1:0]   IP_V4         = 4'd4;
    localparam logic [IP_IHL_W-1:0]   IHL_PLAIN     = 4'd5;
    localparam logic [IP_PROT_W-1:0]  PROT_TCP      = 8'd6;
    localparam logic [IP_PROT_W-1:0]  PROT_UDP      = 8'd17;
    localparam logic [LEN_W-1:0]      UDP_HDR_BYTES = 16'd8;

    // Low bit of each field inside the first flit.
    localparam int OFS_ETH_TYPE  = 400;
    localparam int OFS_IP_VER    = 396;
    localparam int OFS_IP_IHL    = 392;
    localparam int OFS_IP_LEN    = 368;
    localparam int OFS_IP_PROT   = 320;
    localparam int OFS_IP_SIP    = 272;
    localparam int OFS_IP_DIP_HI = 256;
    localparam int OFS_IP_DIP_LO = 240;
    localparam int OFS_L4_SPORT  = 224;
    localparam int OFS_L4_DPORT  = 208;
    localparam int OFS_TCP_DO    = 140;
    localparam int OFS_TCP_FLAGS = 128;

    // Width of one output record as held in the output buffer.
    localparam int META_REC_W = PKT_ID_W + FLITS_W + IP_PROT_W + LEN_W
                              + 2 * IP_ADDR_W + 2 * PORT_W + TCP_FLAGS_W + 2;

    typedef enum logic [1:0] {CLS_TCP, CLS_UDP, CLS_OTHER} prot_class_e;
    typedef enum logic {PKT_ETH, PKT_PCIE} pkt_flags_e;
    typedef enum logic [1:0] {BUF_EMPTY, BUF_ONE, BUF_TWO} buf_state_e;

endpackage

//--- source/header_decode.sv
`timescale 1ns/1ps

module header_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [parser_pkg::FLIT_W-1:0]       in_pkt_data,
    input  logic                                in_pkt_valid,
    input  logic                                in_pkt_sop,
    input  logic                                in_pkt_eop,
    input  logic [parser_pkg::EMPTY_W-1:0]      in_pkt_empty,
    input  logic [parser_pkg::PKT_ID_W-1:0]     in_meta_pkt_id,
    input  logic [parser_pkg::FLITS_W-1:0]      in_meta_flits,
    input  logic                                in_meta_valid,
    output logic                                in_ready,
    output logic                                dec_valid,
    input  logic                                dec_ready,
    output logic [parser_pkg::ETH_TYPE_W-1:0]   dec_eth_type,
    output logic [parser_pkg::IP_VER_W-1:0]     dec_ip_ver,
    output logic [parser_pkg::IP_IHL_W-1:0]     dec_ip_ihl,
    output logic [parser_pkg::LEN_W-1:0]        dec_ip_len,
    output logic [parser_pkg::IP_PROT_W-1:0]    dec_ip_prot,
    output logic [parser_pkg::IP_ADDR_W-1:0]    dec_sip,
    output logic [parser_pkg::IP_ADDR_W-1:0]    dec_dip,
    output logic [parser_pkg::PORT_W-1:0]       dec_sport,
    output logic [parser_pkg::PORT_W-1:0]       dec_dport,
    output logic [parser_pkg::TCP_DO_W-1:0]     dec_tcp_do,
    output logic [parser_pkg::TCP_FLAGS_W-1:0]  dec_tcp_flags,
    output logic [parser_pkg::PKT_ID_W-1:0]     dec_pkt_id,
    output logic [parser_pkg::FLITS_W-1:0]      dec_flits
);
    import parser_pkg::*;

    localparam int DIP_HALF_W = IP_ADDR_W / 2;

    logic beat;
    logic single_flit;

    // The register can take a new beat when empty or when it drains now.
    assign in_ready = !dec_valid || dec_ready;

    assign beat        = in_pkt_valid && in_meta_valid && in_ready;
    assign single_flit = in_pkt_sop && in_pkt_eop;

    // Headers always sit in the first 64 bytes, so in_pkt_empty
    // carries nothing the decoder needs.

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (beat) begin
            // Multi-flit beats are absorbed and leave the stage empty.
            dec_valid <= single_flit;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat && single_flit) begin
            dec_eth_type  <= in_pkt_data[OFS_ETH_TYPE +: ETH_TYPE_W];
            dec_ip_ver    <= in_pkt_data[OFS_IP_VER +: IP_VER_W];
            dec_ip_ihl    <= in_pkt_data[OFS_IP_IHL +: IP_IHL_W];
            dec_ip_len    <= in_pkt_data[OFS_IP_LEN +: LEN_W];
            dec_ip_prot   <= in_pkt_data[OFS_IP_PROT +: IP_PROT_W];
            dec_sip       <= in_pkt_data[OFS_IP_SIP +: IP_ADDR_W];
            // Destination address straddles the lane 2 / lane 1 boundary.
            dec_dip       <= {in_pkt_data[OFS_IP_DIP_HI +: DIP_HALF_W],
                              in_pkt_data[OFS_IP_DIP_LO +: DIP_HALF_W]};
            dec_sport     <= in_pkt_data[OFS_L4_SPORT +: PORT_W];
            dec_dport     <= in_pkt_data[OFS_L4_DPORT +: PORT_W];
            dec_tcp_do    <= in_pkt_data[OFS_TCP_DO +: TCP_DO_W];
            dec_tcp_flags <= in_pkt_data[OFS_TCP_FLAGS +: TCP_FLAGS_W];
            dec_pkt_id    <= in_meta_pkt_id;
            dec_flits     <= in_meta_flits;
        end
    end

endmodule

//--- source/flow_classify.sv
`timescale 1ns/1ps

module flow_classify (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                disable_pcie,
    input  logic                                dec_valid,
    output logic                                dec_ready,
    input  logic [parser_pkg::ETH_TYPE_W-1:0]   dec_eth_type,
    input  logic [parser_pkg::IP_VER_W-1:0]     dec_ip_ver,
    input  logic [parser_pkg::IP_IHL_W-1:0]     dec_ip_ihl,
    input  logic [parser_pkg::LEN_W-1:0]        dec_ip_len,
    input  logic [parser_pkg::IP_PROT_W-1:0]    dec_ip_prot,
    input  logic [parser_pkg::IP_ADDR_W-1:0]    dec_sip,
    input  logic [parser_pkg::IP_ADDR_W-1:0]    dec_dip,
    input  logic [parser_pkg::PORT_W-1:0]       dec_sport,
    input  logic [parser_pkg::PORT_W-1:0]       dec_dport,
    input  logic [parser_pkg::TCP_DO_W-1:0]     dec_tcp_do,
    input  logic [parser_pkg::TCP_FLAGS_W-1:0]  dec_tcp_flags,
    input  logic [parser_pkg::PKT_ID_W-1:0]     dec_pkt_id,
    input  logic [parser_pkg::FLITS_W-1:0]      dec_flits,
    output logic                                cls_valid,
    input  logic                                cls_ready,
    output logic [parser_pkg::PKT_ID_W-1:0]     cls_pkt_id,
    output logic [parser_pkg::FLITS_W-1:0]      cls_flits,
    output logic [parser_pkg::IP_PROT_W-1:0]    cls_prot,
    output logic [parser_pkg::LEN_W-1:0]        cls_len,
    output logic [parser_pkg::IP_ADDR_W-1:0]    cls_sip,
    output logic [parser_pkg::IP_ADDR_W-1:0]    cls_dip,
    output logic [parser_pkg::PORT_W-1:0]       cls_sport,
    output logic [parser_pkg::PORT_W-1:0]       cls_dport,
    output logic [parser_pkg::TCP_FLAGS_W-1:0]  cls_tcp_flags,
    output parser_pkg::pkt_flags_e              cls_pkt_flags,
    output logic                                cls_supported
);
    import parser_pkg::*;

    prot_class_e            prot_class;
    logic                   supported;
    logic                   tcp_syn;
    logic [LEN_W-1:0]       ip_hdr_bytes;
    logic [LEN_W-1:0]       l4_hdr_bytes;
    logic [IP_ADDR_W-1:0]   sip;
    logic [PORT_W-1:0]      sport;
    logic [PORT_W-1:0]      dport;
    logic                   load;

    assign dec_ready = !cls_valid || cls_ready;
    assign load      = dec_valid && dec_ready;
    assign tcp_syn   = dec_tcp_flags[1];

    always_comb begin
        case (dec_ip_prot)
            PROT_TCP: prot_class = CLS_TCP;
            PROT_UDP: prot_class = CLS_UDP;
            default:  prot_class = CLS_OTHER;
        endcase

        supported = (dec_eth_type == PROT_ETH) && (dec_ip_ver == IP_V4)
                 && (dec_ip_ihl == IHL_PLAIN) && (prot_class != CLS_OTHER);

        // Header sizes are counted in 32-bit words.
        ip_hdr_bytes = LEN_W'({dec_ip_ihl, 2'b00});
        l4_hdr_bytes = (prot_class == CLS_TCP) ? LEN_W'({dec_tcp_do, 2'b00}) : UDP_HDR_BYTES;

        // New TCP connections and UDP look up on destination only.
        sip   = '0;
        sport = '0;
        dport = '0;
        case (prot_class)
            CLS_TCP: begin
                dport = dec_dport;
                if (!tcp_syn) begin
                    sip   = dec_sip;
                    sport = dec_sport;
                end
            end
            CLS_UDP: dport = dec_dport;
            default: dport = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cls_valid <= 1'b0;
        end else if (dec_ready) begin
            cls_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cls_pkt_id    <= dec_pkt_id;
            cls_flits     <= dec_flits;
            cls_prot      <= dec_ip_prot;
            cls_len       <= dec_ip_len - ip_hdr_bytes - l4_hdr_bytes;
            cls_sip       <= sip;
            cls_dip       <= dec_dip;
            cls_sport     <= sport;
            cls_dport     <= dport;
            cls_tcp_flags <= dec_tcp_flags;
            cls_pkt_flags <= disable_pcie ? PKT_ETH : PKT_PCIE;
            cls_supported <= supported;
        end
    end

endmodule

//--- source/meta_result.sv
`timescale 1ns/1ps

module meta_result (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cls_valid,
    output logic                                cls_ready,
    input  logic [parser_pkg::PKT_ID_W-1:0]     cls_pkt_id,
    input  logic [parser_pkg::FLITS_W-1:0]      cls_flits,
    input  logic [parser_pkg::IP_PROT_W-1:0]    cls_prot,
    input  logic [parser_pkg::LEN_W-1:0]        cls_len,
    input  logic [parser_pkg::IP_ADDR_W-1:0]    cls_sip,
    input  logic [parser_pkg::IP_ADDR_W-1:0]    cls_dip,
    input  logic [parser_pkg::PORT_W-1:0]       cls_sport,
    input  logic [parser_pkg::PORT_W-1:0]       cls_dport,
    input  logic [parser_pkg::TCP_FLAGS_W-1:0]  cls_tcp_flags,
    input  parser_pkg::pkt_flags_e              cls_pkt_flags,
    input  logic                                cls_supported,
    output logic                                out_meta_valid,
    input  logic                                out_meta_ready,
    output logic [parser_pkg::PKT_ID_W-1:0]     out_pkt_id,
    output logic [parser_pkg::FLITS_W-1:0]      out_flits,
    output logic [parser_pkg::IP_PROT_W-1:0]    out_prot,
    output logic [parser_pkg::LEN_W-1:0]        out_len,
    output logic [parser_pkg::IP_ADDR_W-1:0]    out_sip,
    output logic [parser_pkg::IP_ADDR_W-1:0]    out_dip,
    output logic [parser_pkg::PORT_W-1:0]       out_sport,
    output logic [parser_pkg::PORT_W-1:0]       out_dport,
    output logic [parser_pkg::TCP_FLAGS_W-1:0]  out_tcp_flags,
    output parser_pkg::pkt_flags_e              out_pkt_flags,
    output logic                                out_supported
);
    import parser_pkg::*;

    buf_state_e             state;
    logic [META_REC_W-1:0]  in_rec;
    logic [META_REC_W-1:0]  head_q;
    logic [META_REC_W-1:0]  tail_q;
    logic                   head_flag;
    logic                   push;
    logic                   pop;

    assign in_rec = {cls_pkt_id, cls_flits, cls_prot, cls_len, cls_sip, cls_dip,
                     cls_sport, cls_dport, cls_tcp_flags, cls_pkt_flags, cls_supported};

    // Head entry drives the output record directly.
    assign {out_pkt_id, out_flits, out_prot, out_len, out_sip, out_dip,
            out_sport, out_dport, out_tcp_flags, head_flag, out_supported} = head_q;
    assign out_pkt_flags = pkt_flags_e'(head_flag);

    // Ready depends on buffer state alone.
    assign cls_ready      = (state != BUF_TWO);
    assign out_meta_valid = (state != BUF_EMPTY);

    assign push = cls_valid && cls_ready;
    assign pop  = out_meta_valid && out_meta_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUF_EMPTY;
        end else begin
            case (state)
                BUF_EMPTY: if (push) state <= BUF_ONE;
                BUF_ONE: begin
                    if (push && !pop) begin
                        state <= BUF_TWO;
                    end else if (pop && !push) begin
                        state <= BUF_EMPTY;
                    end
                end
                BUF_TWO: if (pop) state <= BUF_ONE;
                default: state <= BUF_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            BUF_EMPTY: if (push) head_q <= in_rec;
            BUF_ONE: begin
                // Pass-through refill when head leaves in the same cycle.
                if (push && pop) begin
                    head_q <= in_rec;
                end else if (push) begin
                    tail_q <= in_rec;
                end
            end
            BUF_TWO: if (pop) head_q <= tail_q;
            default: ;
        endcase
    end

endmodule

//--- source/pkt_parser_top.sv
`timescale 1ns/1ps

module pkt_parser_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                disable_pcie,
    input  logic [parser_pkg::FLIT_W-1:0]       in_pkt_data,
    input  logic                                in_pkt_valid,
    output logic                                in_pkt_ready,
    input  logic                                in_pkt_sop,
    input  logic                                in_pkt_eop,
    input  logic [parser_pkg::EMPTY_W-1:0]      in_pkt_empty,
    input  logic [parser_pkg::PKT_ID_W-1:0]     in_meta_pkt_id,
    input  logic [parser_pkg::FLITS_W-1:0]      in_meta_flits,
    input  logic                                in_meta_valid,
    output logic                                in_meta_ready,
    output logic                                out_meta_valid,
    input  logic                                out_meta_ready,
    output logic [parser_pkg::PKT_ID_W-1:0]     out_pkt_id,
    output logic [parser_pkg::FLITS_W-1:0]      out_flits,
    output logic [parser_pkg::IP_PROT_W-1:0]    out_prot,
    output logic [parser_pkg::LEN_W-1:0]        out_len,
    output logic [parser_pkg::IP_ADDR_W-1:0]    out_sip,
    output logic [parser_pkg::IP_ADDR_W-1:0]    out_dip,
    output logic [parser_pkg::PORT_W-1:0]       out_sport,
    output logic [parser_pkg::PORT_W-1:0]       out_dport,
    output logic [parser_pkg::TCP_FLAGS_W-1:0]  out_tcp_flags,
    output parser_pkg::pkt_flags_e              out_pkt_flags,
    output logic                                out_supported
);
    import parser_pkg::*;

    logic                    in_ready;
    logic                    dec_valid;
    logic                    dec_ready;
    logic [ETH_TYPE_W-1:0]   dec_eth_type;
    logic [IP_VER_W-1:0]     dec_ip_ver;
    logic [IP_IHL_W-1:0]     dec_ip_ihl;
    logic [LEN_W-1:0]        dec_ip_len;
    logic [IP_PROT_W-1:0]    dec_ip_prot;
    logic [IP_ADDR_W-1:0]    dec_sip;
    logic [IP_ADDR_W-1:0]    dec_dip;
    logic [PORT_W-1:0]       dec_sport;
    logic [PORT_W-1:0]       dec_dport;
    logic [TCP_DO_W-1:0]     dec_tcp_do;
    logic [TCP_FLAGS_W-1:0]  dec_tcp_flags;
    logic [PKT_ID_W-1:0]     dec_pkt_id;
    logic [FLITS_W-1:0]      dec_flits;
    logic                    cls_valid;
    logic                    cls_ready;
    logic [PKT_ID_W-1:0]     cls_pkt_id;
    logic [FLITS_W-1:0]      cls_flits;
    logic [IP_PROT_W-1:0]    cls_prot;
    logic [LEN_W-1:0]        cls_len;
    logic [IP_ADDR_W-1:0]    cls_sip;
    logic [IP_ADDR_W-1:0]    cls_dip;
    logic [PORT_W-1:0]       cls_sport;
    logic [PORT_W-1:0]       cls_dport;
    logic [TCP_FLAGS_W-1:0]  cls_tcp_flags;
    pkt_flags_e              cls_pkt_flags;
    logic                    cls_supported;

    // Frame and metadata beats are taken together.
    assign in_pkt_ready  = in_ready;
    assign in_meta_ready = in_ready;

    header_decode decode_i (
        .clk, .rst, .in_pkt_data, .in_pkt_valid, .in_pkt_sop, .in_pkt_eop,
        .in_pkt_empty, .in_meta_pkt_id, .in_meta_flits, .in_meta_valid,
        .in_ready, .dec_valid, .dec_ready, .dec_eth_type, .dec_ip_ver,
        .dec_ip_ihl, .dec_ip_len, .dec_ip_prot, .dec_sip, .dec_dip,
        .dec_sport, .dec_dport, .dec_tcp_do, .dec_tcp_flags, .dec_pkt_id,
        .dec_flits
    );

    flow_classify classify_i (
        .clk, .rst, .disable_pcie, .dec_valid, .dec_ready, .dec_eth_type,
        .dec_ip_ver, .dec_ip_ihl, .dec_ip_len, .dec_ip_prot, .dec_sip,
        .dec_dip, .dec_sport, .dec_dport, .dec_tcp_do, .dec_tcp_flags,
        .dec_pkt_id, .dec_flits, .cls_valid, .cls_ready, .cls_pkt_id,
        .cls_flits, .cls_prot, .cls_len, .cls_sip, .cls_dip, .cls_sport,
        .cls_dport, .cls_tcp_flags, .cls_pkt_flags, .cls_supported
    );

    meta_result result_i (
        .clk, .rst, .cls_valid, .cls_ready, .cls_pkt_id, .cls_flits,
        .cls_prot, .cls_len, .cls_sip, .cls_dip, .cls_sport, .cls_dport,
        .cls_tcp_flags, .cls_pkt_flags, .cls_supported, .out_meta_valid,
        .out_meta_ready, .out_pkt_id, .out_flits, .out_prot, .out_len,
        .out_sip, .out_dip, .out_sport, .out_dport, .out_tcp_flags,
        .out_pkt_flags, .out_supported
    );

endmodule

//--- verif/parser_model.svh
`ifndef PARSER_MODEL_SVH
`define PARSER_MODEL_SVH

// One expected output record.
typedef struct packed {
    logic [PKT_ID_W-1:0]    pkt_id;
    logic [FLITS_W-1:0]     flits;
    logic [IP_PROT_W-1:0]   prot;
    logic [LEN_W-1:0]       len;
    logic [IP_ADDR_W-1:0]   sip;
    logic [IP_ADDR_W-1:0]   dip;
    logic [PORT_W-1:0]      sport;
    logic [PORT_W-1:0]      dport;
    logic [TCP_FLAGS_W-1:0] tcp_flags;
    logic                   pkt_flags;
    logic                   supported;
} rec_t;

// Fibonacci LFSR, taps 32 22 2 1, one step per returned bit.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

// Random background with the header fields laid on top.
function automatic logic [FLIT_W-1:0] build_frame(
    input logic [15:0] eth, input logic [3:0] ver, input logic [3:0] ihl,
    input logic [15:0] ip_len, input logic [7:0] prot, input logic [31:0] sip,
    input logic [31:0] dip, input logic [15:0] sport, input logic [15:0] dport,
    input logic [3:0] tdo, input logic [8:0] flags);
    logic [FLIT_W-1:0] d;
    for (int i = 0; i < FLIT_W / 32; i++) begin
        d[i*32 +: 32] = rand_bits(32);
    end
    d[OFS_ETH_TYPE +: 16]  = eth;
    d[OFS_IP_VER +: 4]     = ver;
    d[OFS_IP_IHL +: 4]     = ihl;
    d[OFS_IP_LEN +: 16]    = ip_len;
    d[OFS_IP_PROT +: 8]    = prot;
    d[OFS_IP_SIP +: 32]    = sip;
    d[OFS_IP_DIP_HI +: 16] = dip[31:16];
    d[OFS_IP_DIP_LO +: 16] = dip[15:0];
    d[OFS_L4_SPORT +: 16]  = sport;
    d[OFS_L4_DPORT +: 16]  = dport;
    d[OFS_TCP_DO +: 4]     = tdo;
    d[OFS_TCP_FLAGS +: 9]  = flags;
    return d;
endfunction

// Expected record from the header fields.
function automatic rec_t expect_record(
    input logic [9:0] pkt_id, input logic [7:0] flits, input logic [15:0] eth,
    input logic [3:0] ver, input logic [3:0] ihl, input logic [15:0] ip_len,
    input logic [7:0] prot, input logic [31:0] sip, input logic [31:0] dip,
    input logic [15:0] sport, input logic [15:0] dport, input logic [3:0] tdo,
    input logic [8:0] flags, input logic pcie_off);
    rec_t r;
    int   l4_bytes;
    int   len_i;
    l4_bytes    = (prot == 8'd6) ? 4 * int'(tdo) : 8;
    len_i       = int'(ip_len) - 4 * int'(ihl) - l4_bytes;
    r.pkt_id    = pkt_id;
    r.flits     = flits;
    r.prot      = prot;
    r.len       = len_i[15:0];
    r.dip       = dip;
    r.tcp_flags = flags;
    r.pkt_flags = pcie_off ? 1'b0 : 1'b1;
    r.supported = (eth == 16'h0800) && (ver == 4'd4) && (ihl == 4'd5)
               && (prot == 8'd6 || prot == 8'd17);
    r.sip   = '0;
    r.sport = '0;
    r.dport = '0;
    if (prot == 8'd6 || prot == 8'd17) begin
        r.dport = dport;
    end
    // SYN is bit 1 of the TCP flags.
    if (prot == 8'd6 && !flags[1]) begin
        r.sip   = sip;
        r.sport = sport;
    end
    return r;
endfunction

`endif

//--- verif/tb_pkt_parser.sv
`timescale 1ns/1ps

module tb_pkt_parser;
    import parser_pkg::*;

    localparam int NUM_BEATS  = 600;
    localparam int MAX_CYCLES = NUM_BEATS * 8 + 200;

    logic                   clk;
    logic                   rst;
    logic                   disable_pcie;
    logic [FLIT_W-1:0]      in_pkt_data;
    logic                   in_pkt_valid;
    logic                   in_pkt_ready;
    logic                   in_pkt_sop;
    logic                   in_pkt_eop;
    logic [EMPTY_W-1:0]     in_pkt_empty;
    logic [PKT_ID_W-1:0]    in_meta_pkt_id;
    logic [FLITS_W-1:0]     in_meta_flits;
    logic                   in_meta_valid;
    logic                   in_meta_ready;
    logic                   out_meta_valid;
    logic                   out_meta_ready;
    logic [PKT_ID_W-1:0]    out_pkt_id;
    logic [FLITS_W-1:0]     out_flits;
    logic [IP_PROT_W-1:0]   out_prot;
    logic [LEN_W-1:0]       out_len;
    logic [IP_ADDR_W-1:0]   out_sip;
    logic [IP_ADDR_W-1:0]   out_dip;
    logic [PORT_W-1:0]      out_sport;
    logic [PORT_W-1:0]      out_dport;
    logic [TCP_FLAGS_W-1:0] out_tcp_flags;
    pkt_flags_e             out_pkt_flags;
    logic                   out_supported;

    logic [31:0] lfsr = 32'hfaf2;

    `include "parser_model.svh"

    rec_t cur_exp;
    logic cur_strict;
    rec_t exp_q[$];
    int   lat_q[$];
    rec_t held_rec;
    logic held;
    int   cycle;
    int   errors;
    int   records;
    int   singles;
    int   pkt_id_next;

    pkt_parser_top dut_i (.*);

    always #5 clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_record(input rec_t e, input rec_t a);
        check_field("out_pkt_id", 32'(e.pkt_id), 32'(a.pkt_id));
        check_field("out_flits", 32'(e.flits), 32'(a.flits));
        check_field("out_prot", 32'(e.prot), 32'(a.prot));
        check_field("out_len", 32'(e.len), 32'(a.len));
        check_field("out_sip", e.sip, a.sip);
        check_field("out_dip", e.dip, a.dip);
        check_field("out_sport", 32'(e.sport), 32'(a.sport));
        check_field("out_dport", 32'(e.dport), 32'(a.dport));
        check_field("out_tcp_flags", 32'(e.tcp_flags), 32'(a.tcp_flags));
        check_field("out_pkt_flags", 32'(e.pkt_flags), 32'(a.pkt_flags));
        check_field("out_supported", 32'(e.supported), 32'(a.supported));
    endtask

    // Monitor. Everything is sampled as it stood before the edge.
    always @(posedge clk) begin
        rec_t act;
        rec_t e;
        int   acc;
        cycle++;
        if (cycle > MAX_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end else if (rst) begin
            if (out_meta_valid) begin
                errors++;
                $display("out_meta_valid is high during reset at %0t", $time);
            end
        end else begin
            // Frame and metadata readies are one shared signal.
            check_field("in_meta_ready", 32'(in_pkt_ready), 32'(in_meta_ready));
            if (in_pkt_valid && in_meta_valid && in_pkt_ready && in_pkt_sop && in_pkt_eop) begin
                exp_q.push_back(cur_exp);
                lat_q.push_back(cur_strict ? cycle : -1);
                singles++;
            end
            act = {out_pkt_id, out_flits, out_prot, out_len, out_sip, out_dip,
                   out_sport, out_dport, out_tcp_flags, out_pkt_flags, out_supported};
            if (held && out_meta_valid && act != held_rec) begin
                errors++;
                $display("Record changed while waiting for ready at %0t", $time);
            end
            if (out_meta_valid && out_meta_ready) begin
                records++;
                held = 1'b0;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Record came out with no single-flit beat behind it at %0t", $time);
                end else begin
                    e   = exp_q.pop_front();
                    acc = lat_q.pop_front();
                    compare_record(e, act);
                    if (acc >= 0 && cycle - acc != 3) begin
                        errors++;
                        $display("Latency of %0d edges instead of 3 at %0t", cycle - acc, $time);
                    end
                end
            end else if (out_meta_valid) begin
                held     = 1'b1;
                held_rec = act;
            end else if (held) begin
                errors++;
                $display("out_meta_valid dropped before transfer at %0t", $time);
                held = 1'b0;
            end
        end
    end

    // Drives n beats; mixed adds random sop/eop, valids and output ready.
    task automatic run_phase(input int n, input logic mixed, input logic pcie_off);
        int               sent;
        logic             pend;
        logic [2:0]       sel;
        logic [15:0]      eth;
        logic [3:0]       ver;
        logic [3:0]       ihl;
        logic [15:0]      ip_len;
        logic [7:0]       prot;
        logic [31:0]      sip;
        logic [31:0]      dip;
        logic [15:0]      sport;
        logic [15:0]      dport;
        logic [3:0]       tdo;
        logic [8:0]       flags;
        logic [1:0]       bad;
        logic [FLITS_W-1:0] meta_flits;
        sent = 0;
        pend = 1'b0;
        do begin
            @(posedge clk);
            if (in_pkt_valid && in_meta_valid && in_pkt_ready) begin
                pend = 1'b0;
            end
            if (!pend && sent < n) begin
                sel    = 3'(rand_bits(3));
                eth    = PROT_ETH;
                ver    = IP_V4;
                ihl    = IHL_PLAIN;
                // Mostly TCP and UDP, some other protocols and bad headers.
                prot   = (sel < 3 || sel == 7) ? PROT_TCP : (sel < 5) ? PROT_UDP : PROT_TCP;
                if (sel == 5) begin
                    prot = 8'(rand_bits(8));
                end
                if (sel == 6) begin
                    bad = 2'(rand_bits(2));
                    if (bad == 0) eth = 16'(rand_bits(16));
                    else if (bad == 1) ver = 4'(rand_bits(4));
                    else ihl = 4'(rand_bits(4));
                end
                ip_len = 16'(rand_bits(16));
                sip    = rand_bits(32);
                dip    = rand_bits(32);
                sport  = 16'(rand_bits(16));
                dport  = 16'(rand_bits(16));
                tdo    = 4'(rand_bits(4));
                flags  = 9'(rand_bits(9));
                if (sel == 7) flags[1] = 1'b1;
                meta_flits = FLITS_W'(rand_bits(8));
                in_pkt_data    <= build_frame(eth, ver, ihl, ip_len, prot, sip, dip,
                                              sport, dport, tdo, flags);
                in_meta_pkt_id <= PKT_ID_W'(pkt_id_next);
                in_meta_flits  <= meta_flits;
                in_pkt_empty   <= EMPTY_W'(rand_bits(6));
                in_pkt_sop     <= mixed ? rand_bits(1) == 1 : 1'b1;
                in_pkt_eop     <= mixed ? rand_bits(1) == 1 : 1'b1;
                cur_exp        <= expect_record(PKT_ID_W'(pkt_id_next), meta_flits, eth,
                                                ver, ihl, ip_len, prot, sip, dip, sport,
                                                dport, tdo, flags, pcie_off);
                cur_strict     <= !mixed;
                pkt_id_next++;
                sent++;
                pend = 1'b1;
            end
            in_pkt_valid   <= pend && (mixed ? rand_bits(2) != 0 : 1'b1);
            in_meta_valid  <= pend && (mixed ? rand_bits(2) != 0 : 1'b1);
            out_meta_ready <= mixed ? rand_bits(8) >= 32'd102 : 1'b1;
        end while (pend || sent < n);
        out_meta_ready <= 1'b1;
        // Last beat reaches the model first, then every record has to leave.
        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        disable_pcie   = 1'b1;
        in_pkt_data    = '0;
        in_pkt_valid   = 1'b0;
        in_pkt_sop     = 1'b0;
        in_pkt_eop     = 1'b0;
        in_pkt_empty   = '0;
        in_meta_pkt_id = '0;
        in_meta_flits  = '0;
        in_meta_valid  = 1'b0;
        out_meta_ready = 1'b1;
        cur_exp        = '0;
        cur_strict     = 1'b0;
        held           = 1'b0;
        cycle          = 0;
        errors         = 0;
        records        = 0;
        singles        = 0;
        pkt_id_next    = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (!in_pkt_ready) begin
            errors++;
            $display("in_pkt_ready is low on the first cycle after reset");
        end
        run_phase(1, 1'b0, 1'b1);
        run_phase(100, 1'b0, 1'b1);
        disable_pcie <= 1'b0;
        run_phase(100, 1'b0, 1'b0);
        disable_pcie <= 1'b1;
        run_phase(199, 1'b1, 1'b1);
        disable_pcie <= 1'b0;
        run_phase(200, 1'b1, 1'b0);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected records never came out", exp_q.size());
        end
        if (records != singles) begin
            errors++;
            $display("Saw %0d records for %0d single-flit beats", records, singles);
        end
        $display("Errors: %0d, records: %0d, single-flit beats: %0d", errors, records, singles);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- pkt_parser.f
source/parser_pkg.sv
source/header_decode.sv
source/flow_classify.sv
source/meta_result.sv
source/pkt_parser_top.sv
+incdir+verif
verif/tb_pkt_parser.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_pkt_parser
FLIST     ?= pkt_parser.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
